/* Bender.yml */
package:
  name: pktgen

dependencies: {}

sources:
  - source/pktgen_pkg.sv
  - source/prbs23_lane.sv
  - source/pktgen_csr.sv
  - source/pktgen_sequencer.sv
  - source/beat_assembler.sv
  - source/pktgen_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/pktgen_tb.sv

/* src.f */
+incdir+bench
source/pktgen_pkg.sv
source/prbs23_lane.sv
source/pktgen_csr.sv
source/pktgen_sequencer.sv
source/beat_assembler.sv
source/pktgen_top.sv
bench/pktgen_tb.sv

/* bench/pktgen_ref.svh */
// Frame rules for the testbench model, included inside the testbench module
// Needs pktgen_pkg imported by the including module
`ifndef PKTGEN_REF_SVH
`define PKTGEN_REF_SVH

// --------------------------------------------------
// Length rules
// --------------------------------------------------
function automatic logic [15:0] clamp_payload_len(input int programmed);
   if (programmed < 46)
      return 16'd40;                 // Short frames padded up
   else if (programmed > 1500)
      return 16'd1494;               // Long frames cut down
   else
      return 16'(programmed - 6);    // Header overhead removed
endfunction

function automatic int payload_beats(input logic [15:0] plen);
   return (int'(plen) + 7) / 8;      // Rounded up to whole beats
endfunction

// One word step of the x^23 + x^18 + 1 sequence
function automatic logic [22:0] prbs23_advance(input logic [22:0] s);
   logic [22:0] r;
   logic        fb;
   r = s;
   for (int n = 0; n < 23; n++) begin
      fb    = r[18] ^ r[0];
      r     = r >> 1;
      r[22] = fb;                    // New bit enters at the top
   end
   return r;
endfunction

// --------------------------------------------------
// Beat idx of a packet, 0 and 1 are the headers
// --------------------------------------------------
function automatic tx_beat_t expected_beat(input int idx, input logic [47:0] dst,
                                           input logic [47:0] src, input logic [15:0] plen,
                                           input logic [15:0] seq, input logic [63:0] word);
   tx_beat_t    b;
   logic [15:0] len_field;
   b         = '0;
   b.valid   = 1'b1;
   len_field = plen + 16'd6;
   if (idx == 0) begin
      b.data = {dst, src[47:32]};
      b.sop  = 1'b1;
   end else if (idx == 1) begin
      b.data = {src[31:0], len_field, seq};
   end else begin
      b.data = word;                                  // Lane bits, lane 0 lowest
      if (idx == payload_beats(plen) + 1) begin
         b.eop   = 1'b1;
         b.empty = 3'((8 - int'(plen) % 8) % 8);     // Unused bytes of last beat
      end
   end
   return b;
endfunction

`endif

/* bench/pktgen_tb.sv */
// Testbench for the frame generator with 4 PRBS lanes
// MAC and length settings are not changed while a run is active
module pktgen_tb
   import pktgen_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   `include "pktgen_ref.svh"

   localparam int          NUM_LANES    = 4;
   localparam int          CLK_PERIOD   = 40;
   localparam int          REG_TIMEOUT  = 20;      // Cycles per register access
   localparam int          BEAT_TIMEOUT = 20000;   // Cycles to wait for packets
   localparam int          IDLE_POLLS   = 200;
   localparam logic [31:0] RAND_SEED    = 32'h0f92738d;

   logic        clk;
   logic        reset;
   logic [7:0]  address;
   logic        write;
   logic        read;
   logic [31:0] writedata;
   logic        waitrequest;
   logic [31:0] readdata;
   logic        tx_ready;
   tx_beat_t    tx;
   logic        random_ready;   // Back-pressure on/off

   // Model state
   logic [3:0][22:0] model_lanes;
   logic [47:0]      cfg_dst;
   logic [47:0]      cfg_src;
   logic [15:0]      cfg_len;     // Clamped payload length
   logic [15:0]      model_seq;
   int               beat_idx;
   int               run_pkts;    // Packets finished in this run
   tx_beat_t         prev_tx;
   logic             prev_stall;

   pktgen_top #(.NUM_LANES(NUM_LANES)) pktgen_top_inst (
      .clk, .reset, .address, .write, .read, .writedata,
      .waitrequest, .readdata, .tx_ready, .tx
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // --------------------------------------------------
   // Checks and aborts
   // --------------------------------------------------
   task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic timeout_abort(input string what);
      $display("Timed out while waiting for %s", what);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
   endtask

   // --------------------------------------------------
   // Register access, held until wait request drops
   // --------------------------------------------------
   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      int n;
      n = 0;
      @(posedge clk);
      address   <= addr;
      writedata <= data;
      write     <= 1'b1;
      do begin
         @(posedge clk);
         n++;
         if (n > REG_TIMEOUT) timeout_abort("register write to finish");
      end while (waitrequest);
      write <= 1'b0;   // Access completes at this edge
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
      int n;
      n = 0;
      @(posedge clk);
      address <= addr;
      read    <= 1'b1;
      do begin
         @(posedge clk);
         n++;
         if (n > REG_TIMEOUT) timeout_abort("register read to finish");
      end while (waitrequest);
      read <= 1'b0;
      @(posedge clk);
      data = readdata;   // Registered one cycle after completion
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [31:0] data,
                            input logic [31:0] mask);
      logic [31:0] val;
      reg_write(addr, data);
      reg_read(addr, val);
      check_equal(val, data & mask, $sformatf("read-back of register %0d", addr));
   endtask

   // --------------------------------------------------
   // Run control
   // --------------------------------------------------
   task automatic set_macs(input logic [47:0] dst, input logic [47:0] src);
      reg_write(ADDR_MACDA0, dst[31:0]);
      reg_write(ADDR_MACDA1, {16'd0, dst[47:32]});
      reg_write(ADDR_MACSA0, src[31:0]);
      reg_write(ADDR_MACSA1, {16'd0, src[47:32]});
      cfg_dst = dst;
      cfg_src = src;
   endtask

   task automatic start_run(input int len, input logic cont);
      cfg_len     = clamp_payload_len(len);
      model_lanes = LANE_SEEDS;   // Lanes reload while idle
      model_seq   = '0;
      beat_idx    = 0;
      run_pkts    = 0;
      reg_write(ADDR_GEN_CTRL, {29'd0, cont, 1'b0, 1'b1});
   endtask

   task automatic wait_packets(input int target);
      int n;
      n = 0;
      while (run_pkts < target) begin
         @(posedge clk);
         n++;
         if (n > BEAT_TIMEOUT) timeout_abort("packets on the output");
      end
   endtask

   // Idle status, then the output register drained
   task automatic wait_idle();
      logic [31:0] stat;
      int          n;
      n = 0;
      reg_read(ADDR_GEN_STAT, stat);
      while (!stat[STAT_IDLE]) begin
         n++;
         if (n > IDLE_POLLS) timeout_abort("the idle status bit");
         reg_read(ADDR_GEN_STAT, stat);
      end
      n = 0;
      while (tx.valid) begin
         @(posedge clk);
         n++;
         if (n > BEAT_TIMEOUT) timeout_abort("the output to drain");
      end
   endtask

   task automatic run_packets(input int len, input int num);
      logic [31:0] cnt;
      int          expect_pkts;
      expect_pkts = (num == 0) ? 1 : num;   // Count 0 still sends one
      reg_write(ADDR_PKTLENGTH, 32'(len));
      reg_write(ADDR_NUMPKTS, 32'(num));
      start_run(len, 1'b0);
      wait_packets(expect_pkts);
      wait_idle();
      check_equal(32'(run_pkts), 32'(expect_pkts), "packets seen");
      reg_read(ADDR_TXPKTCNT, cnt);
      check_equal(cnt, 32'(expect_pkts), "packet count register");
   endtask

   // --------------------------------------------------
   // Output ready, random or held high
   // --------------------------------------------------
   initial begin : ready_drive
      void'($urandom(RAND_SEED));
      tx_ready <= 1'b0;
      forever begin
         @(posedge clk);
         if (random_ready)
            tx_ready <= 1'($urandom & 1);   // About half the cycles
         else
            tx_ready <= 1'b1;
      end
   end

   // Monitor compares accepted beats with the model
   always @(posedge clk) begin : monitor
      tx_beat_t    exp;
      logic [91:0] flat;
      if (!reset) begin
         if (prev_stall)
            check_equal(tx, prev_tx, "beat held under back-pressure");
         if (tx.valid && tx_ready) begin
            flat = model_lanes;
            exp  = expected_beat(beat_idx, cfg_dst, cfg_src, cfg_len, model_seq, flat[63:0]);
            check_equal(tx, exp, $sformatf("packet %0d beat %0d", run_pkts, beat_idx));
            if (beat_idx >= 1) begin   // Lanes step after length and payload beats
               for (int i = 0; i < NUM_LANES; i++)
                  model_lanes[i] = prbs23_advance(model_lanes[i]);
            end
            if (exp.eop) begin
               beat_idx  = 0;
               model_seq = model_seq + 16'd1;
               run_pkts++;
            end else begin
               beat_idx++;
            end
         end
         prev_stall = tx.valid && !tx_ready;
         prev_tx    = tx;
      end
   end

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   initial begin : stimulus
      logic [31:0] val;
      reset        <= 1'b1;
      address      <= '0;
      write        <= 1'b0;
      read         <= 1'b0;
      writedata    <= '0;
      random_ready <= 1'b0;
      model_lanes  = LANE_SEEDS;
      model_seq    = '0;
      beat_idx     = 0;
      run_pkts     = 0;
      prev_stall   = 1'b0;
      cfg_dst      = '0;
      cfg_src      = '0;
      cfg_len      = '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      // Register map after reset
      reg_read(ADDR_GEN_STAT, val);
      check_equal(val, 32'h1, "status after reset");
      check_reg(ADDR_MACDA0, 32'h89ab_cdef, 32'hffff_ffff);
      check_reg(ADDR_MACDA1, 32'hdead_0123, 32'h0000_ffff);
      check_reg(ADDR_MACSA0, 32'h7654_3210, 32'hffff_ffff);
      check_reg(ADDR_MACSA1, 32'hbeef_4567, 32'h0000_ffff);
      check_reg(ADDR_NUMPKTS, 32'h8000_0005, 32'hffff_ffff);
      check_reg(ADDR_PKTLENGTH, 32'hffff_c0de, 32'h0000_3fff);
      check_reg(ADDR_TXPKTCNT, 32'hffff_ffff, 32'h0000_0000);   // Read only
      check_reg(ADDR_GEN_CTRL, 32'hffff_fffc, 32'h0000_0006);   // Start bit kept low
      reg_write(ADDR_GEN_CTRL, 32'h0);
      reg_read(8'd9, val);
      check_equal(val, 32'h0, "unmapped address 9");
      reg_read(8'hff, val);
      check_equal(val, 32'h0, "unmapped address 255");
      check_equal(tx.valid, 1'b0, "output valid while idle");

      // Fixed run, ready high
      set_macs(48'h0200_5e10_2030, 48'h0200_5ea0_b0c1);
      run_packets(64, 3);

      // Length clamp cases
      run_packets(20, 1);
      run_packets(1600, 1);
      run_packets(61, 1);
      run_packets(100, 1);
      run_packets(64, 0);

      // Random back-pressure
      random_ready <= 1'b1;
      run_packets(64, 4);
      run_packets(61, 2);
      random_ready <= 1'b0;

      // Continuous run past the count, then stop
      reg_write(ADDR_PKTLENGTH, 32'd100);
      reg_write(ADDR_NUMPKTS, 32'd2);
      start_run(100, 1'b1);
      wait_packets(5);
      reg_write(ADDR_GEN_CTRL, 32'h6);   // Stop with continuous still set
      wait_idle();
      reg_read(ADDR_TXPKTCNT, val);
      check_equal(val, 32'(run_pkts), "packet count after stop");

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* source/pktgen_top.sv */
// Ethernet test-frame generator without CRC
// NUM_LANES must be 3 or 4
module pktgen_top
   import pktgen_pkg::*;
#(
   parameter int NUM_LANES = 4
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [7:0]  address,
   input  logic        write,
   input  logic        read,
   input  logic [31:0] writedata,
   output logic        waitrequest,
   output logic [31:0] readdata,
   input  logic        tx_ready,
   output tx_beat_t    tx
);

   gen_cfg_t                        cfg;
   frame_ctl_t                      ctl;
   logic                            start;
   logic                            stop;
   logic                            stop_done;
   logic                            idle;
   logic [31:0]                     tx_pkt_count;
   logic                            lane_load;
   logic                            lane_step;
   logic                            take;
   logic [NUM_LANES*LANE_WIDTH-1:0] lane_bits;

   pktgen_csr csr_inst (
      .clk, .reset, .address, .write, .read, .writedata,
      .waitrequest, .readdata,
      .idle, .tx_pkt_count, .stop_done,
      .cfg, .start, .stop
   );

   pktgen_sequencer seq_inst (
      .clk, .reset, .cfg, .start, .stop, .take,
      .ctl, .lane_load, .lane_step, .stop_done, .idle, .tx_pkt_count
   );

   // --------------------------------------------------
   // PRBS lanes, lane 0 in the LSBs
   // --------------------------------------------------
   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      prbs23_lane #(.SEED(LANE_SEEDS[i])) lane_inst (
         .clk, .reset,
         .load (lane_load),
         .step (lane_step),
         .bits (lane_bits[i*LANE_WIDTH +: LANE_WIDTH])
      );
   end

   beat_assembler #(.NUM_LANES(NUM_LANES)) asm_inst (
      .clk, .reset, .ctl, .lane_bits, .tx_ready, .take, .tx
   );

endmodule

/* source/beat_assembler.sv */
// Output stage. One beat register with ready/valid on the streaming side
// Needs NUM_LANES * 23 >= 64 so the payload word is fully covered
module beat_assembler
   import pktgen_pkg::*;
#(
   parameter int NUM_LANES = 4
) (
   input  logic                              clk,
   input  logic                              reset,
   input  frame_ctl_t                        ctl,
   input  logic [NUM_LANES*LANE_WIDTH-1:0]   lane_bits,
   input  logic                              tx_ready,
   output logic                              take,
   output tx_beat_t                          tx
);

   logic [BEAT_WIDTH-1:0] beat_data;
   logic [BEAT_WIDTH-1:0] data_q;
   logic [2:0]            empty_q;
   logic                  valid_q;
   logic                  sop_q;
   logic                  eop_q;
   logic                  load;

   // --------------------------------------------------
   // Data select by beat kind
   // --------------------------------------------------
   always_comb begin
      case (ctl.kind)
         hdr_mac:     beat_data = {ctl.dst_mac, ctl.src_mac_hi};
         hdr_len_seq: beat_data = {ctl.src_mac_lo, ctl.len_seq};
         default:     beat_data = lane_bits[BEAT_WIDTH-1:0];   // Lane 0 in the LSBs
      endcase
   end

   // Slot is free or its beat leaves this cycle
   assign take = ~valid_q | tx_ready;
   assign load = ctl.valid & take;

   // Flags under reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid_q <= 1'b0;
         sop_q   <= 1'b0;
         eop_q   <= 1'b0;
      end else if (take) begin
         valid_q <= ctl.valid;               // Drops when nothing follows
         sop_q   <= ctl.valid & ctl.sop;
         eop_q   <= ctl.valid & ctl.eop;
      end
   end

   // Payload held while stalled
   always_ff @(posedge clk) begin
      if (load) begin
         data_q  <= beat_data;
         empty_q <= ctl.empty;
      end
   end

   assign tx.data  = data_q;
   assign tx.valid = valid_q;
   assign tx.sop   = sop_q;
   assign tx.eop   = eop_q;
   assign tx.empty = empty_q;

endmodule

/* source/pktgen_sequencer.sv */
// Framing FSM. Two header beats then ceil(L/8) payload beats per packet
// Length is latched at each packet start so a register write mid-packet waits
module pktgen_sequencer
   import pktgen_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  gen_cfg_t    cfg,
   input  logic        start,
   input  logic        stop,
   input  logic        take,
   output frame_ctl_t  ctl,
   output logic        lane_load,
   output logic        lane_step,
   output logic        stop_done,
   output logic        idle,
   output logic [31:0] tx_pkt_count
);

   typedef enum logic [2:0] {
      st_idle,
      st_mac,       // Destination MAC and upper source MAC
      st_len_seq,   // Lower source MAC, length and sequence number
      st_payload,
      st_eop        // Run-end decision
   } state_t;

   state_t      state;
   logic [15:0] len_clamp;
   logic [15:0] len_q;      // Clamped payload length of this packet
   logic [15:0] rem_q;      // Payload bytes still to send
   logic [15:0] seq_q;
   logic [31:0] pkt_cnt;
   logic        xfer;
   logic        last_beat;
   logic        run_done;

   // --------------------------------------------------
   // Payload length clamp
   // --------------------------------------------------
   always_comb begin
      if ({2'b00, cfg.pkt_length} < MIN_FRAME)
         len_clamp = MIN_FRAME - HDR_OVERHEAD;        // 40 bytes
      else if ({2'b00, cfg.pkt_length} > MAX_FRAME)
         len_clamp = MAX_FRAME - HDR_OVERHEAD;        // 1494 bytes
      else
         len_clamp = {2'b00, cfg.pkt_length} - HDR_OVERHEAD;
   end

   assign xfer      = ctl.valid & take;                    // Beat moves to assembler
   assign last_beat = (rem_q <= 16'(BEAT_BYTES));
   assign run_done  = stop | (~cfg.continuous & (pkt_cnt >= cfg.num_pkts));

   // --------------------------------------------------
   // State and counters
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state   <= st_idle;
         len_q   <= '0;
         rem_q   <= '0;
         seq_q   <= '0;
         pkt_cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  state <= st_mac;
                  len_q <= len_clamp;
                  rem_q <= len_clamp;
                  seq_q <= '0;
               end
            end
            st_mac:
               if (xfer) state <= st_len_seq;
            st_len_seq: begin
               if (xfer) begin
                  state   <= st_payload;
                  pkt_cnt <= pkt_cnt + 32'd1;   // Counted on the length/sequence beat
               end
            end
            st_payload: begin
               if (xfer) begin
                  rem_q <= rem_q - 16'(BEAT_BYTES);
                  if (last_beat)
                     state <= st_eop;
               end
            end
            st_eop: begin
               if (run_done) begin
                  state <= st_idle;
               end else begin
                  state <= st_mac;
                  len_q <= len_clamp;
                  rem_q <= len_clamp;
                  seq_q <= seq_q + 16'd1;
               end
            end
            default: state <= st_idle;
         endcase
         if (start)
            pkt_cnt <= '0;
      end
   end

   // --------------------------------------------------
   // Beat request
   // --------------------------------------------------
   always_comb begin
      ctl            = '0;
      ctl.valid      = (state == st_mac) | (state == st_len_seq) | (state == st_payload);
      ctl.kind       = payload;
      if (state == st_mac)
         ctl.kind = hdr_mac;
      else if (state == st_len_seq)
         ctl.kind = hdr_len_seq;
      ctl.sop        = (state == st_mac);
      ctl.eop        = (state == st_payload) & last_beat;
      // (8 - L mod 8) mod 8 on the last beat
      ctl.empty      = ctl.eop ? 3'd0 - rem_q[2:0] : 3'd0;
      ctl.dst_mac    = cfg.dst_mac;
      ctl.src_mac_hi = cfg.src_mac[47:32];
      ctl.src_mac_lo = cfg.src_mac[31:0];
      ctl.len_seq    = {len_q + HDR_OVERHEAD, seq_q};
   end

   // Lanes step on the second header beat and on every payload beat
   assign lane_step    = xfer & ((state == st_len_seq) | (state == st_payload));
   assign lane_load    = (state == st_idle);   // Sequence runs on across packets
   assign stop_done    = (state == st_eop);
   assign idle         = (state == st_idle);
   assign tx_pkt_count = pkt_cnt;

endmodule

/* source/pktgen_csr.sv */
// Register bank with a wait-request strobe on the first cycle of each access
// Master must drop read or write after completion, a held strobe repeats the access
module pktgen_csr
   import pktgen_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic [7:0]  address,
   input  logic        write,
   input  logic        read,
   input  logic [31:0] writedata,
   output logic        waitrequest,
   output logic [31:0] readdata,
   input  logic        idle,
   input  logic [31:0] tx_pkt_count,
   input  logic        stop_done,
   output gen_cfg_t    cfg,
   output logic        start,
   output logic        stop
);

   logic [47:0] dst_mac;
   logic [47:0] src_mac;
   logic [31:0] num_pkts;
   logic [13:0] pkt_length;
   logic        continuous;
   logic        start_q;      // One-cycle start pulse
   logic        stop_q;       // Held until the sequencer ends the packet
   logic        wr_d;
   logic        rd_d;
   logic        wr_en;

   // --------------------------------------------------
   // Wait request on the rising edge of read or write
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_d <= 1'b0;
         rd_d <= 1'b0;
      end else begin
         wr_d <= write;
         rd_d <= read;
      end
   end

   assign waitrequest = (write & ~wr_d) | (read & ~rd_d);
   assign wr_en       = write & ~waitrequest;   // Write lands in the second cycle

   // --------------------------------------------------
   // Register writes
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         dst_mac    <= '0;
         src_mac    <= '0;
         num_pkts   <= '0;
         pkt_length <= '0;
         continuous <= 1'b0;
         start_q    <= 1'b0;
         stop_q     <= 1'b0;
      end else begin
         start_q <= 1'b0;
         if (stop_done)
            stop_q <= 1'b0;   // Packet finished
         if (wr_en) begin
            case (address)
               ADDR_MACDA0:    dst_mac[31:0]  <= writedata;
               ADDR_MACDA1:    dst_mac[47:32] <= writedata[15:0];
               ADDR_MACSA0:    src_mac[31:0]  <= writedata;
               ADDR_MACSA1:    src_mac[47:32] <= writedata[15:0];
               ADDR_NUMPKTS:   num_pkts       <= writedata;
               ADDR_PKTLENGTH: pkt_length     <= writedata[13:0];
               ADDR_GEN_CTRL: begin
                  start_q    <= writedata[CTRL_START];
                  stop_q     <= writedata[CTRL_STOP];   // Write wins over stop_done
                  continuous <= writedata[CTRL_CONT];
               end
               default: ;   // Read-only or unmapped
            endcase
         end
      end
   end

   // Read-back with unused bits as zero
   always_ff @(posedge clk) begin
      if (read) begin
         case (address)
            ADDR_MACDA0:    readdata <= dst_mac[31:0];
            ADDR_MACDA1:    readdata <= {16'd0, dst_mac[47:32]};
            ADDR_MACSA0:    readdata <= src_mac[31:0];
            ADDR_MACSA1:    readdata <= {16'd0, src_mac[47:32]};
            ADDR_NUMPKTS:   readdata <= num_pkts;
            ADDR_PKTLENGTH: readdata <= {18'd0, pkt_length};
            ADDR_TXPKTCNT:  readdata <= tx_pkt_count;
            ADDR_GEN_CTRL:  readdata <= {29'd0, continuous, stop_q, start_q};
            ADDR_GEN_STAT:  readdata <= 32'(idle) << STAT_IDLE;
            default:        readdata <= 32'd0;
         endcase
      end
   end

   // Settings to the sequencer
   assign cfg.dst_mac    = dst_mac;
   assign cfg.src_mac    = src_mac;
   assign cfg.num_pkts   = num_pkts;
   assign cfg.pkt_length = pkt_length;
   assign cfg.continuous = continuous;
   assign cfg.rsvd       = '0;

   assign start = start_q;
   assign stop  = stop_q;

endmodule

/* source/prbs23_lane.sv */
// PRBS-23 lane, x^23 + x^18 + 1, advancing 23 bit-steps per step pulse
// Load has priority over step
module prbs23_lane #(
   parameter logic [22:0] SEED = 23'h05eed0
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        load,
   input  logic        step,
   output logic [22:0] bits
);

   localparam int WIDTH = 23;

   logic [WIDTH-1:0] lfsr_q;
   logic [WIDTH-1:0] lfsr_nxt;

   // --------------------------------------------------
   // 23 shift iterations unrolled into one word step
   // --------------------------------------------------
   always_comb begin
      lfsr_nxt = lfsr_q;
      for (int i = 0; i < WIDTH; i++) begin
         // Shift right, feedback enters at the top
         lfsr_nxt = {lfsr_nxt[18] ^ lfsr_nxt[0], lfsr_nxt[WIDTH-1:1]};
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         lfsr_q <= '0;
      end else if (load) begin
         lfsr_q <= SEED;       // Reloaded while the generator is idle
      end else if (step) begin
         lfsr_q <= lfsr_nxt;
      end
   end

   assign bits = lfsr_q;   // LSB is the first bit of the sequence

endmodule

/* source/pktgen_pkg.sv */
// Shared register map, length limits, lane seeds and bus structs
// Seeds exist for 4 lanes only and the payload needs at least 3 of them
package pktgen_pkg;

   // --------------------------------------------------
   // Register map
   // --------------------------------------------------
   localparam logic [7:0] ADDR_MACDA0    = 8'd0;   // Destination MAC [31:0]
   localparam logic [7:0] ADDR_MACDA1    = 8'd1;   // Destination MAC [47:32]
   localparam logic [7:0] ADDR_MACSA0    = 8'd2;   // Source MAC [31:0]
   localparam logic [7:0] ADDR_MACSA1    = 8'd3;   // Source MAC [47:32]
   localparam logic [7:0] ADDR_NUMPKTS   = 8'd4;
   localparam logic [7:0] ADDR_PKTLENGTH = 8'd5;
   localparam logic [7:0] ADDR_TXPKTCNT  = 8'd6;   // Read only
   localparam logic [7:0] ADDR_GEN_CTRL  = 8'd7;
   localparam logic [7:0] ADDR_GEN_STAT  = 8'd8;   // Read only

   localparam int CTRL_START = 0;   // Self-clearing
   localparam int CTRL_STOP  = 1;   // Cleared at end of packet
   localparam int CTRL_CONT  = 2;
   localparam int STAT_IDLE  = 0;

   // --------------------------------------------------
   // Frame length limits
   // --------------------------------------------------
   localparam logic [15:0] MIN_FRAME    = 16'd46;
   localparam logic [15:0] MAX_FRAME    = 16'd1500;
   localparam logic [15:0] HDR_OVERHEAD = 16'd6;

   // PRBS lanes and beat geometry
   localparam int LANE_WIDTH = 23;
   localparam logic [3:0][22:0] LANE_SEEDS = {23'h35eed3, 23'h25eed2,
                                              23'h15eed1, 23'h05eed0};
   localparam int BEAT_BYTES = 8;
   localparam int BEAT_WIDTH = 64;

   typedef struct packed {
      logic [47:0] dst_mac;
      logic [47:0] src_mac;
      logic [31:0] num_pkts;
      logic [13:0] pkt_length;   // Programmed frame length in bytes
      logic        continuous;
      logic [2:0]  rsvd;
   } gen_cfg_t;

   typedef enum logic [1:0] {hdr_mac, hdr_len_seq, payload} beat_kind_t;

   typedef struct packed {
      logic        valid;
      beat_kind_t  kind;
      logic        sop;
      logic        eop;
      logic [2:0]  empty;
      logic [47:0] dst_mac;
      logic [15:0] src_mac_hi;
      logic [31:0] src_mac_lo;   // Second header beat only
      logic [31:0] len_seq;      // Length field high, sequence number low
   } frame_ctl_t;

   typedef struct packed {
      logic [63:0] data;
      logic        valid;
      logic        sop;
      logic        eop;
      logic [2:0]  empty;
   } tx_beat_t;

endpackage
